// File: Bender.yml
package:
  name: dll_tx

export_include_dirs:
  - .

sources:
  - dll_pkg.sv
  - axis_skid_buffer.sv
  - fc_credit_gate.sv
  - lcrc_engine.sv
  - dll_framer.sv
  - dll_tx_top.sv
  - target: test
    files:
      - tb_dll_tx.sv

// File: axis_skid_buffer.sv
`default_nettype none

module axis_skid_buffer #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     s_valid_i,
  input  payload_t s_payload_i,
  output logic     s_ready_o,
  output logic     m_valid_o,
  output payload_t m_payload_o,
  input  logic     m_ready_i
);

  payload_t main_q;
  payload_t skid_q;
  logic     main_valid_q;
  logic     skid_valid_q;
  logic     main_load;

  // ready comes straight from a flop, drops only with both entries full
  assign s_ready_o   = !skid_valid_q;
  assign m_valid_o   = main_valid_q;
  assign m_payload_o = main_q;

  // main entry free or draining this cycle
  assign main_load = m_ready_i || !main_valid_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
    end else begin
      if (main_load) begin
        if (skid_valid_q) begin
          main_valid_q <= 1'b1;
          skid_valid_q <= 1'b0;
        end else begin
          main_valid_q <= s_valid_i;
        end
      end else if (s_valid_i && s_ready_o) begin
        skid_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (main_load) begin
      if (skid_valid_q) begin
        main_q <= skid_q;
      end else if (s_valid_i) begin
        main_q <= s_payload_i;
      end
    end else if (s_valid_i && s_ready_o) begin
      // downstream stalled, park the beat
      skid_q <= s_payload_i;
    end
  end

  a_payload_stable : assert property (
    @(posedge clk_i) disable iff (rst_i)
    m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_payload_o)
  );

endmodule

`default_nettype wire

// File: dll_consts.svh
`ifndef DLL_CONSTS_SVH
`define DLL_CONSTS_SVH

// stream geometry, one dword per beat
`define DLL_DATA_W 32
`define DLL_KEEP_W 4

// tx sequence number width
`define DLL_SEQ_W 12

// flow control counter widths
`define DLL_HDR_CRED_W 8
`define DLL_DATA_CRED_W 12

// lcrc in reflected form, lsb first
`define DLL_LCRC_POLY 32'hEDB8_8320
`define DLL_LCRC_SEED 32'hFFFF_FFFF

`endif

// File: dll_framer.sv
`default_nettype none

`include "dll_consts.svh"

module dll_framer (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   hdr_valid_i,
  input  dll_pkg::in_beat_t      hdr_payload_i,
  output logic                   hdr_ready_o,
  output logic [`DLL_DATA_W-1:0] head_data_o,
  input  logic                   credit_ok_i,
  output logic                   tlp_start_o,
  output logic                   crc_clear_o,
  output logic                   crc_en_o,
  output logic                   crc_two_bytes_o,
  output logic [`DLL_DATA_W-1:0] crc_data_o,
  input  logic [`DLL_DATA_W-1:0] crc_value_i,
  output logic                   out_valid_o,
  output dll_pkg::out_beat_t     out_payload_o,
  input  logic                   out_ready_i,
  output logic [`DLL_SEQ_W-1:0]  seq_num_o,
  output logic                   tlp_sent_o
);
  import dll_pkg::*;

  framer_state_e          state_q;
  framer_state_e          state_d;
  logic [`DLL_SEQ_W-1:0]  seq_q;
  logic [15:0]            hold_q;
  logic                   tail_hi_q;
  logic                   pend_valid_q;
  logic [`DLL_DATA_W-1:0] pend_data_q;
  logic                   pend_lo_q;
  logic                   pend_hi_q;
  logic                   pend_load_ok;
  logic                   hdr_fire;
  logic                   form_fire;
  logic [`DLL_DATA_W-1:0] form_data;
  logic                   form_lo;
  logic                   form_hi;

  // one word stage ahead of the output, words are folded when formed
  // so the crc is complete by the time its bytes go out
  assign pend_load_ok = !pend_valid_q || out_ready_i;
  assign head_data_o  = hdr_payload_i.data;

  always_comb begin
    state_d         = state_q;
    hdr_ready_o     = 1'b0;
    form_fire       = 1'b0;
    form_data       = {hdr_payload_i.data[15:0], hold_q};
    form_lo         = 1'b0;
    form_hi         = 1'b0;
    crc_clear_o     = 1'b0;
    crc_two_bytes_o = 1'b0;
    case (state_q)
      ST_IDLE: begin
        hdr_ready_o = pend_load_ok && credit_ok_i;
        // seq high byte goes first on the wire
        form_data = {hdr_payload_i.data[15:0], seq_q[7:0], 4'h0, seq_q[11:8]};
        if (hdr_valid_i && hdr_ready_o) begin
          form_fire   = 1'b1;
          crc_clear_o = 1'b1;
          state_d     = hdr_payload_i.last ? ST_CRC_TAIL : ST_STREAM;
        end
      end
      ST_STREAM: begin
        hdr_ready_o = pend_load_ok;
        if (hdr_valid_i && pend_load_ok) begin
          form_fire = 1'b1;
          if (hdr_payload_i.last) begin
            state_d = ST_CRC_TAIL;
          end
        end
      end
      ST_CRC_TAIL: begin
        if (pend_load_ok) begin
          form_fire = 1'b1;
          if (tail_hi_q) begin
            // lcrc bytes 2 and 3 only
            form_hi   = 1'b1;
            form_data = '0;
            state_d   = ST_GAP;
          end else begin
            // last two tlp bytes, lcrc bytes 0 and 1 filled at output
            form_lo         = 1'b1;
            form_data       = {16'h0, hold_q};
            crc_two_bytes_o = 1'b1;
          end
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  assign hdr_fire    = hdr_valid_i && hdr_ready_o;
  assign tlp_start_o = hdr_fire && (state_q == ST_IDLE);
  assign crc_en_o    = form_fire && !form_hi;
  assign crc_data_o  = form_data;
  assign tlp_sent_o  = (state_q == ST_GAP);
  assign seq_num_o   = seq_q;
  assign out_valid_o = pend_valid_q;

  always_comb begin
    out_payload_o.keep = pend_hi_q ? 4'b0011 : 4'b1111;
    out_payload_o.last = pend_hi_q;
    if (pend_hi_q) begin
      out_payload_o.data = {16'h0, crc_value_i[31:16]};
    end else if (pend_lo_q) begin
      out_payload_o.data = {crc_value_i[15:0], pend_data_q[15:0]};
    end else begin
      out_payload_o.data = pend_data_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q      <= ST_IDLE;
      seq_q        <= '0;
      tail_hi_q    <= 1'b0;
      pend_valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == ST_GAP) begin
        seq_q <= seq_q + 1'b1;
      end
      if (form_lo || form_hi) begin
        tail_hi_q <= form_lo;
      end
      if (pend_load_ok) begin
        pend_valid_q <= form_fire;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    // upper half waits for the next dword
    if (hdr_fire) begin
      hold_q <= hdr_payload_i.data[31:16];
    end
    if (form_fire) begin
      pend_data_q <= form_data;
      pend_lo_q   <= form_lo;
      pend_hi_q   <= form_hi;
    end
  end

endmodule

`default_nettype wire

// File: dll_pkg.sv
`default_nettype none

`include "dll_consts.svh"

package dll_pkg;

  // beat entering the link layer, always a full dword
  typedef struct packed {
    logic [`DLL_DATA_W-1:0] data;
    logic                   last;
  } in_beat_t;

  // framed beat leaving the link layer
  typedef struct packed {
    logic [`DLL_DATA_W-1:0] data;
    logic [`DLL_KEEP_W-1:0] keep;
    logic                   last;
  } out_beat_t;

  // credit class of a tlp
  typedef enum logic [1:0] {
    TLP_POSTED,
    TLP_NON_POSTED,
    TLP_COMPLETION
  } tlp_class_e;

  // framer states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_STREAM,
    ST_CRC_TAIL,
    ST_GAP
  } framer_state_e;

endpackage

`default_nettype wire

// File: dll_tx_top.sv
`default_nettype none

`include "dll_consts.svh"

module dll_tx_top (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic [`DLL_DATA_W-1:0]      s_data_i,
  input  logic                        s_last_i,
  input  logic                        s_valid_i,
  output logic                        s_ready_o,
  output logic [`DLL_DATA_W-1:0]      m_data_o,
  output logic [`DLL_KEEP_W-1:0]      m_keep_o,
  output logic                        m_last_o,
  output logic                        m_valid_o,
  input  logic                        m_ready_i,
  input  logic [`DLL_HDR_CRED_W-1:0]  tx_fc_ph_i,
  input  logic [`DLL_DATA_CRED_W-1:0] tx_fc_pd_i,
  input  logic [`DLL_HDR_CRED_W-1:0]  tx_fc_nph_i,
  input  logic [`DLL_DATA_CRED_W-1:0] tx_fc_npd_i,
  output logic [`DLL_SEQ_W-1:0]       seq_num_o,
  output logic                        tlp_sent_o,
  output logic [`DLL_HDR_CRED_W-1:0]  ph_consumed_o,
  output logic [`DLL_DATA_CRED_W-1:0] pd_consumed_o,
  output logic [`DLL_HDR_CRED_W-1:0]  nph_consumed_o,
  output logic [`DLL_DATA_CRED_W-1:0] npd_consumed_o
);
  import dll_pkg::*;

  in_beat_t               s_beat;
  in_beat_t               hdr_beat;
  logic                   hdr_valid;
  logic                   hdr_ready;
  logic [`DLL_DATA_W-1:0] head_data;
  logic                   credit_ok;
  logic                   tlp_start;
  logic                   crc_clear;
  logic                   crc_en;
  logic                   crc_two_bytes;
  logic [`DLL_DATA_W-1:0] crc_data;
  logic [`DLL_DATA_W-1:0] crc_value;
  out_beat_t              out_beat;
  logic                   out_valid;
  logic                   out_ready;
  out_beat_t              m_beat;

  assign s_beat   = '{data: s_data_i, last: s_last_i};
  assign m_data_o = m_beat.data;
  assign m_keep_o = m_beat.keep;
  assign m_last_o = m_beat.last;

  axis_skid_buffer #(
    .payload_t (in_beat_t)
  ) i_in_skid (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .s_valid_i   (s_valid_i),
    .s_payload_i (s_beat),
    .s_ready_o   (s_ready_o),
    .m_valid_o   (hdr_valid),
    .m_payload_o (hdr_beat),
    .m_ready_i   (hdr_ready)
  );

  fc_credit_gate i_gate (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .head_data_i    (head_data),
    .tlp_start_i    (tlp_start),
    .tx_fc_ph_i     (tx_fc_ph_i),
    .tx_fc_nph_i    (tx_fc_nph_i),
    .tx_fc_pd_i     (tx_fc_pd_i),
    .tx_fc_npd_i    (tx_fc_npd_i),
    .credit_ok_o    (credit_ok),
    .ph_consumed_o  (ph_consumed_o),
    .nph_consumed_o (nph_consumed_o),
    .pd_consumed_o  (pd_consumed_o),
    .npd_consumed_o (npd_consumed_o)
  );

  lcrc_engine i_lcrc (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .crc_clear_i     (crc_clear),
    .crc_en_i        (crc_en),
    .crc_two_bytes_i (crc_two_bytes),
    .crc_data_i      (crc_data),
    .crc_value_o     (crc_value)
  );

  dll_framer i_framer (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .hdr_valid_i     (hdr_valid),
    .hdr_payload_i   (hdr_beat),
    .hdr_ready_o     (hdr_ready),
    .head_data_o     (head_data),
    .credit_ok_i     (credit_ok),
    .tlp_start_o     (tlp_start),
    .crc_clear_o     (crc_clear),
    .crc_en_o        (crc_en),
    .crc_two_bytes_o (crc_two_bytes),
    .crc_data_o      (crc_data),
    .crc_value_i     (crc_value),
    .out_valid_o     (out_valid),
    .out_payload_o   (out_beat),
    .out_ready_i     (out_ready),
    .seq_num_o       (seq_num_o),
    .tlp_sent_o      (tlp_sent_o)
  );

  axis_skid_buffer #(
    .payload_t (out_beat_t)
  ) i_out_skid (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .s_valid_i   (out_valid),
    .s_payload_i (out_beat),
    .s_ready_o   (out_ready),
    .m_valid_o   (m_valid_o),
    .m_payload_o (m_beat),
    .m_ready_i   (m_ready_i)
  );

endmodule

`default_nettype wire

// File: fc_credit_gate.sv
`default_nettype none

`include "dll_consts.svh"

module fc_credit_gate (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic [`DLL_DATA_W-1:0]      head_data_i,
  input  logic                        tlp_start_i,
  input  logic [`DLL_HDR_CRED_W-1:0]  tx_fc_ph_i,
  input  logic [`DLL_HDR_CRED_W-1:0]  tx_fc_nph_i,
  input  logic [`DLL_DATA_CRED_W-1:0] tx_fc_pd_i,
  input  logic [`DLL_DATA_CRED_W-1:0] tx_fc_npd_i,
  output logic                        credit_ok_o,
  output logic [`DLL_HDR_CRED_W-1:0]  ph_consumed_o,
  output logic [`DLL_HDR_CRED_W-1:0]  nph_consumed_o,
  output logic [`DLL_DATA_CRED_W-1:0] pd_consumed_o,
  output logic [`DLL_DATA_CRED_W-1:0] npd_consumed_o
);
  import dll_pkg::*;

  logic [7:0]                  fmt_type;
  logic [9:0]                  length;
  logic [10:0]                 len_dw;
  logic [10:0]                 len_cred;
  logic [`DLL_DATA_CRED_W-1:0] req_data;
  tlp_class_e                  tlp_class;
  logic [`DLL_HDR_CRED_W-1:0]  ph_room;
  logic [`DLL_HDR_CRED_W-1:0]  nph_room;
  logic [`DLL_DATA_CRED_W-1:0] pd_room;
  logic [`DLL_DATA_CRED_W-1:0] npd_room;

  // header dword 0 fields
  assign fmt_type = head_data_i[7:0];
  assign length   = {head_data_i[17:16], head_data_i[31:24]};

  // zero length means 1024 dwords
  assign len_dw   = (length == 10'd0) ? 11'd1024 : {1'b0, length};
  assign len_cred = (len_dw + 11'd3) >> 2;
  assign req_data = fmt_type[6] ?
                    {{(`DLL_DATA_CRED_W - 11){1'b0}}, len_cred} : '0;

  always_comb begin
    if (fmt_type == 8'h0A || fmt_type == 8'h4A) begin
      tlp_class = TLP_COMPLETION;
    end else if (fmt_type == 8'h40 || fmt_type == 8'h60 || fmt_type[7:3] == 5'b01110) begin
      tlp_class = TLP_POSTED;
    end else begin
      tlp_class = TLP_NON_POSTED;
    end
  end

  // headroom wraps with the counter width
  assign ph_room  = tx_fc_ph_i - ph_consumed_o;
  assign nph_room = tx_fc_nph_i - nph_consumed_o;
  assign pd_room  = tx_fc_pd_i - pd_consumed_o;
  assign npd_room = tx_fc_npd_i - npd_consumed_o;

  always_comb begin
    case (tlp_class)
      TLP_POSTED:     credit_ok_o = (ph_room != '0) && (pd_room >= req_data);
      TLP_NON_POSTED: credit_ok_o = (nph_room != '0) && (npd_room >= req_data);
      default:        credit_ok_o = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ph_consumed_o  <= '0;
      nph_consumed_o <= '0;
      pd_consumed_o  <= '0;
      npd_consumed_o <= '0;
    end else if (tlp_start_i) begin
      if (tlp_class == TLP_POSTED) begin
        ph_consumed_o <= ph_consumed_o + 1'b1;
        pd_consumed_o <= pd_consumed_o + req_data;
      end else if (tlp_class == TLP_NON_POSTED) begin
        nph_consumed_o <= nph_consumed_o + 1'b1;
        npd_consumed_o <= npd_consumed_o + req_data;
      end
    end
  end

  // the framer must never start a tlp the gate has not cleared
  a_start_has_credit : assert property (
    @(posedge clk_i) disable iff (rst_i)
    tlp_start_i |-> credit_ok_o
  );

endmodule

`default_nettype wire

// File: flist.f
+incdir+.
dll_pkg.sv
axis_skid_buffer.sv
fc_credit_gate.sv
lcrc_engine.sv
dll_framer.sv
dll_tx_top.sv
tb_dll_tx.sv

// File: lcrc_engine.sv
`default_nettype none

`include "dll_consts.svh"

module lcrc_engine (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   crc_clear_i,
  input  logic                   crc_en_i,
  input  logic                   crc_two_bytes_i,
  input  logic [`DLL_DATA_W-1:0] crc_data_i,
  output logic [`DLL_DATA_W-1:0] crc_value_o
);

  logic [31:0] crc_q;
  logic [31:0] crc_base;

  // bit serial fold, byte 0 first and lsb first within a byte
  function automatic logic [31:0] crc_fold(
    input logic [31:0] crc,
    input logic [31:0] data,
    input logic        two_bytes
  );
    logic [31:0] c;
    c = crc;
    for (int i = 0; i < 32; i++) begin
      if (!two_bytes || i < 16) begin
        c = (c >> 1) ^ (`DLL_LCRC_POLY & {32{c[0] ^ data[i]}});
      end
    end
    return c;
  endfunction

  // a clear in the same cycle folds on top of the seed
  assign crc_base = crc_clear_i ? `DLL_LCRC_SEED : crc_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      crc_q <= `DLL_LCRC_SEED;
    end else if (crc_en_i) begin
      crc_q <= crc_fold(crc_base, crc_data_i, crc_two_bytes_i);
    end else if (crc_clear_i) begin
      crc_q <= `DLL_LCRC_SEED;
    end
  end

  // register already holds reflected form, only the final complement left
  assign crc_value_o = ~crc_q;

endmodule

`default_nettype wire

// File: tb_dll_tx.sv
`default_nettype none

`include "dll_consts.svh"

module tb_dll_tx;
  import dll_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int RAND_TLPS  = 12;
  // 1 + RAND_TLPS + 5 + 1 + 1 frames over the whole run
  localparam int TOTAL_TLPS = 20;

  logic                        clk_i;
  logic                        rst_i;
  logic [`DLL_DATA_W-1:0]      s_data_i;
  logic                        s_last_i;
  logic                        s_valid_i;
  logic                        s_ready_o;
  logic [`DLL_DATA_W-1:0]      m_data_o;
  logic [`DLL_KEEP_W-1:0]      m_keep_o;
  logic                        m_last_o;
  logic                        m_valid_o;
  logic                        m_ready_i;
  logic [`DLL_HDR_CRED_W-1:0]  tx_fc_ph_i;
  logic [`DLL_DATA_CRED_W-1:0] tx_fc_pd_i;
  logic [`DLL_HDR_CRED_W-1:0]  tx_fc_nph_i;
  logic [`DLL_DATA_CRED_W-1:0] tx_fc_npd_i;
  logic [`DLL_SEQ_W-1:0]       seq_num_o;
  logic                        tlp_sent_o;
  logic [`DLL_HDR_CRED_W-1:0]  ph_consumed_o;
  logic [`DLL_DATA_CRED_W-1:0] pd_consumed_o;
  logic [`DLL_HDR_CRED_W-1:0]  nph_consumed_o;
  logic [`DLL_DATA_CRED_W-1:0] npd_consumed_o;

  out_beat_t                   exp_q [$];
  logic [`DLL_DATA_W-1:0]      tlp_words [0:31];
  logic [31:0]                 lfsr_q;
  logic [`DLL_SEQ_W-1:0]       exp_seq;
  logic [`DLL_HDR_CRED_W-1:0]  exp_ph;
  logic [`DLL_HDR_CRED_W-1:0]  exp_nph;
  logic [`DLL_DATA_CRED_W-1:0] exp_pd;
  logic [`DLL_DATA_CRED_W-1:0] exp_npd;
  int                          queued_cnt;
  int                          sent_cnt;
  int                          words_seen;
  int                          errors;
  int                          test_err0;
  int                          tests_run;
  int                          tests_failed;
  string                       cur_test;
  logic                        stall_en;
  logic                        next_ready;

  dll_tx_top i_dut (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .s_data_i       (s_data_i),
    .s_last_i       (s_last_i),
    .s_valid_i      (s_valid_i),
    .s_ready_o      (s_ready_o),
    .m_data_o       (m_data_o),
    .m_keep_o       (m_keep_o),
    .m_last_o       (m_last_o),
    .m_valid_o      (m_valid_o),
    .m_ready_i      (m_ready_i),
    .tx_fc_ph_i     (tx_fc_ph_i),
    .tx_fc_pd_i     (tx_fc_pd_i),
    .tx_fc_nph_i    (tx_fc_nph_i),
    .tx_fc_npd_i    (tx_fc_npd_i),
    .seq_num_o      (seq_num_o),
    .tlp_sent_o     (tlp_sent_o),
    .ph_consumed_o  (ph_consumed_o),
    .pd_consumed_o  (pd_consumed_o),
    .nph_consumed_o (nph_consumed_o),
    .npd_consumed_o (npd_consumed_o)
  );

  always begin
    #(CLK_PERIOD / 2);
    clk_i = ~clk_i;
  end

  // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic tlp_class_e class_of(input logic [7:0] fmt);
    if (fmt == 8'h0A || fmt == 8'h4A) begin
      return TLP_COMPLETION;
    end
    if (fmt == 8'h40 || fmt == 8'h60 || (fmt >= 8'h70 && fmt <= 8'h77)) begin
      return TLP_POSTED;
    end
    return TLP_NON_POSTED;
  endfunction

  function automatic logic [`DLL_DATA_CRED_W-1:0] data_need(input logic [7:0] fmt,
                                                           input logic [9:0] len);
    int dw;
    dw = (len == 10'd0) ? 1024 : int'(len);
    if (!fmt[6]) begin
      return '0;
    end
    return (dw + 3) / 4;
  endfunction

  // standard crc-32, one byte at a time
  function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] b);
    logic [31:0] c;
    c = crc ^ {24'h0, b};
    for (int k = 0; k < 8; k++) begin
      c = c[0] ? ((c >> 1) ^ `DLL_LCRC_POLY) : (c >> 1);
    end
    return c;
  endfunction

  // expected output words for tlp_words[0 .. n-1] with the given sequence
  function automatic void build_expected_frame(input int n, input logic [`DLL_SEQ_W-1:0] seq);
    logic [7:0]  bytes [0:127];
    logic [31:0] crc;
    out_beat_t   beat;
    int          nb;
    bytes[0] = {4'h0, seq[11:8]};
    bytes[1] = seq[7:0];
    nb = 2;
    for (int i = 0; i < n; i++) begin
      for (int b = 0; b < 4; b++) begin
        bytes[nb] = tlp_words[i][8*b +: 8];
        nb++;
      end
    end
    crc = `DLL_LCRC_SEED;
    for (int k = 0; k < nb; k++) begin
      crc = crc_byte(crc, bytes[k]);
    end
    crc = ~crc;
    for (int b = 0; b < 4; b++) begin
      bytes[nb] = crc[8*b +: 8];
      nb++;
    end
    for (int w = 0; w * 4 < nb; w++) begin
      beat = '0;
      for (int b = 0; b < 4; b++) begin
        if (w * 4 + b < nb) begin
          beat.data[8*b +: 8] = bytes[w*4 + b];
          beat.keep[b] = 1'b1;
        end
      end
      beat.last = (w * 4 + 4 >= nb);
      exp_q.push_back(beat);
    end
  endfunction

  task automatic check_word(input string what, input logic [`DLL_DATA_W-1:0] want,
                            input logic [`DLL_DATA_W-1:0] got);
    if (got !== want) begin
      $display("Fail %s %s: expected %h actual %h", cur_test, what, want, got);
      errors++;
    end
  endtask

  task automatic check_keep(input string what, input logic [`DLL_KEEP_W-1:0] want,
                            input logic [`DLL_KEEP_W-1:0] got);
    if (got !== want) begin
      $display("Fail %s %s: expected %b actual %b", cur_test, what, want, got);
      errors++;
    end
  endtask

  task automatic check_last(input string what, input logic want, input logic got);
    if (got !== want) begin
      $display("Fail %s %s: expected %b actual %b", cur_test, what, want, got);
      errors++;
    end
  endtask

  task automatic check_count(input string what, input logic [`DLL_DATA_CRED_W-1:0] want,
                             input logic [`DLL_DATA_CRED_W-1:0] got);
    if (got !== want) begin
      $display("Fail %s %s: expected %0d actual %0d", cur_test, what, want, got);
      errors++;
    end
  endtask

  // output side, sampled mid cycle where the handshake is stable
  always @(negedge clk_i) begin : monitor
    out_beat_t want;
    if (!rst_i && m_valid_o && m_ready_i) begin
      words_seen++;
      if (exp_q.size() == 0) begin
        $display("Error %s: output word %h arrived with no frame pending", cur_test, m_data_o);
        errors++;
      end else begin
        want = exp_q.pop_front();
        check_word("data", want.data, m_data_o);
        check_keep("keep", want.keep, m_keep_o);
        check_last("last", want.last, m_last_o);
      end
    end
  end

  always @(negedge clk_i) begin
    if (!rst_i && tlp_sent_o) begin
      sent_cnt++;
    end
  end

  // random sink stalls, drawn mid cycle and applied after the edge
  always @(negedge clk_i) begin
    next_ready = stall_en ? (rand_bits(2) != 32'd0) : 1'b1;
  end

  always @(posedge clk_i) begin
    #2;
    m_ready_i = next_ready;
  end

  task automatic send_beat(input logic [`DLL_DATA_W-1:0] data, input logic last);
    s_valid_i = 1'b1;
    s_data_i  = data;
    s_last_i  = last;
    @(negedge clk_i);
    while (!s_ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #2;
    s_valid_i = 1'b0;
  endtask

  task automatic send_tlp(input logic [7:0] fmt, input logic [9:0] len, input int n);
    logic [31:0] misc;
    tlp_class_e  cls;
    misc = rand_bits(14);
    tlp_words[0] = {len[7:0], misc[13:8], len[9:8], misc[7:0], fmt};
    for (int i = 1; i < n; i++) begin
      tlp_words[i] = rand_bits(32);
    end
    build_expected_frame(n, exp_seq);
    exp_seq++;
    queued_cnt++;
    cls = class_of(fmt);
    if (cls == TLP_POSTED) begin
      exp_ph++;
      exp_pd += data_need(fmt, len);
    end else if (cls == TLP_NON_POSTED) begin
      exp_nph++;
      exp_npd += data_need(fmt, len);
    end
    for (int i = 0; i < n; i++) begin
      send_beat(tlp_words[i], i == n - 1);
    end
  endtask

  task automatic wait_done();
    @(posedge clk_i);
    while (sent_cnt != queued_cnt || exp_q.size() != 0) begin
      @(posedge clk_i);
    end
    #2;
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_err0 = errors;
  endtask

  task automatic end_test();
    check_count("seq_num", sent_cnt[11:0], seq_num_o);
    check_count("ph_consumed", exp_ph, ph_consumed_o);
    check_count("nph_consumed", exp_nph, nph_consumed_o);
    check_count("pd_consumed", exp_pd, pd_consumed_o);
    check_count("npd_consumed", exp_npd, npd_consumed_o);
    tests_run++;
    if (errors != test_err0) begin
      tests_failed++;
      $display("test %s: failed with %0d errors", cur_test, errors - test_err0);
    end else begin
      $display("test %s: ok", cur_test);
    end
  endtask

  initial begin : stimulus
    logic [7:0]  fmt;
    logic [9:0]  len;
    logic [31:0] rnd;
    int          base_words;
    int          base_sent;
    clk_i = 1'b0;
    rst_i = 1'b1;
    s_data_i = '0;
    s_last_i = 1'b0;
    s_valid_i = 1'b0;
    m_ready_i = 1'b0;
    tx_fc_ph_i = 8'hFF;
    tx_fc_nph_i = 8'hFF;
    tx_fc_pd_i = 12'hFFF;
    tx_fc_npd_i = 12'hFFF;
    lfsr_q = 32'h897f8925;
    exp_seq = '0;
    {exp_ph, exp_nph, exp_pd, exp_npd} = '0;
    {queued_cnt, sent_cnt, words_seen, errors} = '0;
    {tests_run, tests_failed, test_err0} = '0;
    stall_en = 1'b0;
    next_ready = 1'b1;
    cur_test = "reset";
    repeat (8) @(posedge clk_i);
    #2;
    rst_i = 1'b0;

    begin_test("single_posted");
    send_tlp(8'h40, 10'd1, 3);
    wait_done();
    end_test();

    begin_test("random_stream");
    stall_en = 1'b1;
    for (int t = 0; t < RAND_TLPS; t++) begin
      rnd = rand_bits(2);
      case (rnd[1:0])
        2'd0:    fmt = 8'h40;
        2'd1:    fmt = 8'h00;
        2'd2:    fmt = 8'h44;
        default: fmt = 8'h4A;
      endcase
      rnd = rand_bits(3);
      len = rnd[9:0] + 10'd1;
      send_tlp(fmt, len, 3 + int'(len));
    end
    wait_done();
    stall_en = 1'b0;
    end_test();

    // zero length posted write counts as 1024 dwords
    begin_test("credit_counters");
    send_tlp(8'h40, 10'd2, 5);
    send_tlp(8'h00, 10'd1, 3);
    send_tlp(8'h44, 10'd1, 4);
    send_tlp(8'h4A, 10'd3, 6);
    send_tlp(8'h40, 10'd0, 4);
    wait_done();
    end_test();

    begin_test("credit_gating");
    tx_fc_ph_i = exp_ph;
    base_words = words_seen;
    base_sent = sent_cnt;
    send_tlp(8'h40, 10'd1, 2);
    repeat (40) @(posedge clk_i);
    #2;
    if (words_seen != base_words || sent_cnt != base_sent) begin
      $display("Error credit_gating: posted TLP went out with no header credit left");
      errors++;
    end
    tx_fc_ph_i = tx_fc_ph_i + 1'b1;
    wait_done();
    end_test();

    // posted header credit is used up again here
    begin_test("completion_bypass");
    send_tlp(8'h0A, 10'd0, 3);
    wait_done();
    end_test();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #((8 + 200 * TOTAL_TLPS) * CLK_PERIOD);
    $display("Error: run timed out with %0d of %0d frames sent", sent_cnt, queued_cnt);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire
